//--- verilog/img_pkg.sv
package img_pkg;

    // ======================================================================
    // Frame geometry
    // ======================================================================
    localparam int img_width   = 16;
    localparam int img_height  = 8;
    localparam int pixel_count = img_width * img_height;
    localparam int pixel_bits  = 12;
    localparam int word_bits   = 16;
    localparam int block_count = 2;
    localparam int addr_bits   = 7;

    // ======================================================================
    // Readout stream layout and statistics
    // ======================================================================
    localparam int header_words   = 4;
    localparam int checksum_words = 2;
    localparam int padding_words  = 2;

    // One sample per tile for highlight and shadow counts
    localparam int stat_tile  = 4;
    // Thumbnail keeps the upper-left corner of every tile
    localparam int thumb_tile = 8;
    localparam int thumb_keep = 2;
    localparam int count_bits = 8;

    typedef struct packed {
        logic                  fv;
        logic                  lv;
        logic [pixel_bits-1:0] pixel;
    } pixel_in_t;

    typedef struct packed {
        logic [$clog2(block_count)-1:0] block;
        logic                           skip;
    } capture_cmd_t;

    typedef struct packed {
        logic [$clog2(block_count)-1:0]       block;
        logic                                 thumb;
        logic [header_words*word_bits-1:0]    header;
    } readout_cmd_t;

    typedef struct packed {
        logic [count_bits-1:0] pixels;
        logic [count_bits-1:0] highlights;
        logic [count_bits-1:0] shadows;
    } capture_status_t;

    typedef struct packed {
        logic                           en;
        logic [$clog2(block_count)-1:0] block;
        logic [addr_bits-1:0]           addr;
        logic [word_bits-1:0]           data;
    } ram_write_t;

endpackage

//--- verilog/frame_capture.sv
module frame_capture (
    input  logic                     clk,
    input  logic                     rst_n,
    input  img_pkg::pixel_in_t       pixel_in,
    input  logic                     capture_req,
    input  img_pkg::capture_cmd_t    capture_cmd,
    output logic                     capture_ack,
    output img_pkg::ram_write_t      ram_wr,
    output img_pkg::capture_status_t status
);

    typedef enum logic [1:0] {
        s_idle,
        s_wait_frame,
        s_capture,
        s_ack
    } state_t;

    state_t                                  state;
    logic                                    fv_prev;
    logic                                    lv_prev;
    logic                                    skip_left;
    logic [$clog2(img_pkg::block_count)-1:0] cap_block;
    logic [$clog2(img_pkg::stat_tile)-1:0]   tile_x;
    logic [$clog2(img_pkg::stat_tile)-1:0]   tile_y;
    logic                                    frame_start;
    logic                                    write_now;
    logic                                    sample_now;
    logic [6:0]                              top_bits;
    logic                                    wr_en;
    logic [img_pkg::addr_bits-1:0]           wr_addr;
    logic [img_pkg::word_bits-1:0]           wr_data;

    assign frame_start = pixel_in.fv && !fv_prev;
    // The first line may already be valid on the frame start cycle
    assign write_now = pixel_in.lv && (state == s_capture ||
                       (state == s_wait_frame && frame_start && !skip_left));
    assign sample_now = write_now && tile_x == '0 && tile_y == '0;
    assign top_bits = pixel_in.pixel[img_pkg::pixel_bits-1 -: 7];

    assign ram_wr = '{en: wr_en, block: cap_block, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= s_idle;
            capture_ack <= 1'b0;
            fv_prev     <= 1'b0;
            lv_prev     <= 1'b0;
            tile_x      <= '0;
            tile_y      <= '0;
            wr_en       <= 1'b0;
            status      <= '0;
        end else begin
            fv_prev <= pixel_in.fv;
            lv_prev <= pixel_in.lv;

            // Statistics sampling grid
            if (!pixel_in.lv)
                tile_x <= '0;
            else if (int'(tile_x) == img_pkg::stat_tile - 1)
                tile_x <= '0;
            else
                tile_x <= tile_x + 1'b1;
            if (!pixel_in.fv)
                tile_y <= '0;
            else if (lv_prev && !pixel_in.lv)
                tile_y <= (int'(tile_y) == img_pkg::stat_tile - 1) ? '0 : tile_y + 1'b1;

            // Pixel word goes out one cycle after sampling
            wr_en <= write_now;
            if (write_now) begin
                wr_addr       <= status.pixels[img_pkg::addr_bits-1:0];
                wr_data       <= {pixel_in.pixel[7:0], 4'b0000, pixel_in.pixel[11:8]};
                status.pixels <= status.pixels + 1'b1;
            end
            if (sample_now) begin
                if (top_bits == '1)
                    status.highlights <= status.highlights + 1'b1;
                else if (top_bits == '0)
                    status.shadows <= status.shadows + 1'b1;
            end

            case (state)
                s_idle: if (capture_req) begin
                    cap_block <= capture_cmd.block;
                    skip_left <= capture_cmd.skip;
                    status    <= '0;
                    state     <= s_wait_frame;
                end
                s_wait_frame: if (frame_start) begin
                    // A skipped frame just re-arms the edge detector
                    if (skip_left)
                        skip_left <= 1'b0;
                    else
                        state <= s_capture;
                end
                s_capture: if (!pixel_in.fv) begin
                    capture_ack <= 1'b1;
                    state       <= s_ack;
                end
                default: if (!capture_req) begin
                    capture_ack <= 1'b0;
                    state       <= s_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/frame_ram.sv
module frame_ram (
    input  logic                                    clk,
    input  img_pkg::ram_write_t                     wr,
    input  logic [$clog2(img_pkg::block_count)-1:0] rd_block,
    input  logic [img_pkg::addr_bits-1:0]           rd_addr,
    output logic [img_pkg::word_bits-1:0]           rd_data
);

    // Block select forms the top address bits
    logic [img_pkg::word_bits-1:0] mem [img_pkg::block_count * img_pkg::pixel_count];

    always_ff @(posedge clk) begin
        if (wr.en)
            mem[{wr.block, wr.addr}] <= wr.data;
        rd_data <= mem[{rd_block, rd_addr}];
    end

endmodule

//--- verilog/fletcher_checksum.sv
module fletcher_checksum (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic                          accept,
    input  logic [img_pkg::word_bits-1:0] word,
    output logic [31:0]                   sum
);

    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [15:0] swapped;
    logic [15:0] next_a;

    // Addition of two 16-bit values modulo 65535
    function automatic logic [15:0] add_mod(input logic [15:0] x, input logic [15:0] y);
        logic [16:0] s;
        s = x + y;
        if (s >= 17'd65535)
            s = s - 17'd65535;
        return s[15:0];
    endfunction

    // Words are summed little-endian
    assign swapped = {word[7:0], word[15:8]};
    assign next_a  = add_mod(sum_a, swapped);
    assign sum     = {sum_b, sum_a};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            sum_a <= '0;
            sum_b <= '0;
        end else if (accept) begin
            sum_a <= next_a;
            sum_b <= add_mod(sum_b, next_a);
        end
    end

endmodule

//--- verilog/readout_sequencer.sv
module readout_sequencer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    readout_req,
    input  img_pkg::readout_cmd_t                   readout_cmd,
    output logic                                    readout_ack,
    output logic [$clog2(img_pkg::block_count)-1:0] rd_block,
    output logic [img_pkg::addr_bits-1:0]           rd_addr,
    input  logic [img_pkg::word_bits-1:0]           rd_data,
    output logic                                    cs_clear,
    output logic                                    cs_accept,
    output logic [img_pkg::word_bits-1:0]           cs_word,
    input  logic [31:0]                             cs_sum,
    output logic                                    readout_valid,
    output logic [img_pkg::word_bits-1:0]           readout_data,
    input  logic                                    readout_ready
);

    typedef enum logic [2:0] {
        s_idle,
        s_header,
        s_pixel,
        s_checksum,
        s_padding,
        s_ack
    } state_t;

    state_t                                                state;
    logic [img_pkg::header_words*img_pkg::word_bits-1:0]   shift;
    logic [$clog2(img_pkg::header_words)-1:0]              word_cnt;
    logic [$clog2(img_pkg::img_width)-1:0]                 x;
    logic [$clog2(img_pkg::img_height)-1:0]                y;
    logic                                                  thumb;
    logic                                                  rd_phase;
    logic                                                  sum_ready;
    logic                                                  out_sum;
    logic                                                  load;
    logic                                                  keep;

    // Output slot is free or being emptied this cycle
    assign load = !readout_valid || readout_ready;
    assign keep = !thumb || ((x % img_pkg::thumb_tile) < img_pkg::thumb_keep &&
                             (y % img_pkg::thumb_tile) < img_pkg::thumb_keep);

    // Only header and pixel words enter the checksum
    assign cs_accept = readout_valid && readout_ready && out_sum;
    assign cs_word   = readout_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= s_idle;
            readout_ack   <= 1'b0;
            readout_valid <= 1'b0;
            cs_clear      <= 1'b0;
            out_sum       <= 1'b0;
            rd_phase      <= 1'b0;
            sum_ready     <= 1'b0;
            word_cnt      <= '0;
        end else begin
            cs_clear <= 1'b0;
            if (readout_valid && readout_ready)
                readout_valid <= 1'b0;

            case (state)
                s_idle: if (readout_req) begin
                    rd_block <= readout_cmd.block;
                    thumb    <= readout_cmd.thumb;
                    shift    <= readout_cmd.header;
                    rd_addr  <= '0;
                    x        <= '0;
                    y        <= '0;
                    word_cnt <= '0;
                    cs_clear <= 1'b1;
                    state    <= s_header;
                end

                // ==========================================================
                // Header words from the most significant end
                // ==========================================================
                s_header: if (load) begin
                    readout_data  <= shift[$bits(shift)-1 -: img_pkg::word_bits];
                    readout_valid <= 1'b1;
                    out_sum       <= 1'b1;
                    shift         <= shift << img_pkg::word_bits;
                    word_cnt      <= word_cnt + 1'b1;
                    if (int'(word_cnt) == img_pkg::header_words - 1) begin
                        word_cnt <= '0;
                        rd_phase <= 1'b0;
                        state    <= s_pixel;
                    end
                end

                // ==========================================================
                // Pixel fetch at one RAM read per two cycles
                // ==========================================================
                s_pixel: begin
                    if (!rd_phase) begin
                        rd_phase <= 1'b1;
                    end else if (load || !keep) begin
                        if (keep) begin
                            readout_data  <= rd_data;
                            readout_valid <= 1'b1;
                            out_sum       <= 1'b1;
                        end
                        rd_phase <= 1'b0;
                        rd_addr  <= rd_addr + 1'b1;
                        if (int'(x) == img_pkg::img_width - 1) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        if (int'(rd_addr) == img_pkg::pixel_count - 1) begin
                            sum_ready <= 1'b0;
                            state     <= s_checksum;
                        end
                    end
                end

                // Sum is final the cycle after the last pixel leaves
                s_checksum: begin
                    if (!sum_ready) begin
                        if (!readout_valid) begin
                            shift[$bits(shift)-1 -: img_pkg::checksum_words*img_pkg::word_bits]
                                <= {cs_sum[7:0], cs_sum[15:8], cs_sum[23:16], cs_sum[31:24]};
                            sum_ready <= 1'b1;
                        end
                    end else if (load) begin
                        readout_data  <= shift[$bits(shift)-1 -: img_pkg::word_bits];
                        readout_valid <= 1'b1;
                        out_sum       <= 1'b0;
                        shift         <= shift << img_pkg::word_bits;
                        word_cnt      <= word_cnt + 1'b1;
                        if (int'(word_cnt) == img_pkg::checksum_words - 1) begin
                            word_cnt <= '0;
                            state    <= s_padding;
                        end
                    end
                end

                s_padding: if (load) begin
                    readout_data  <= '0;
                    readout_valid <= 1'b1;
                    out_sum       <= 1'b0;
                    word_cnt      <= word_cnt + 1'b1;
                    if (int'(word_cnt) == img_pkg::padding_words - 1) begin
                        word_cnt <= '0;
                        state    <= s_ack;
                    end
                end

                // Ack once the last padding word has gone
                default: begin
                    if (!readout_ack && !readout_valid)
                        readout_ack <= 1'b1;
                    if (readout_ack && !readout_req) begin
                        readout_ack <= 1'b0;
                        state       <= s_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- verilog/img_controller.sv
module img_controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  img_pkg::pixel_in_t            pixel_in,
    input  logic                          capture_req,
    input  img_pkg::capture_cmd_t         capture_cmd,
    output logic                          capture_ack,
    output img_pkg::capture_status_t      status,
    input  logic                          readout_req,
    input  img_pkg::readout_cmd_t         readout_cmd,
    output logic                          readout_ack,
    output logic                          readout_valid,
    output logic [img_pkg::word_bits-1:0] readout_data,
    input  logic                          readout_ready
);

    img_pkg::ram_write_t                     ram_wr;
    logic [$clog2(img_pkg::block_count)-1:0] rd_block;
    logic [img_pkg::addr_bits-1:0]           rd_addr;
    logic [img_pkg::word_bits-1:0]           rd_data;
    logic                                    cs_clear;
    logic                                    cs_accept;
    logic [img_pkg::word_bits-1:0]           cs_word;
    logic [31:0]                             cs_sum;

    // ======================================================================
    // Capture path into frame memory
    // ======================================================================
    frame_capture capture_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_in    (pixel_in),
        .capture_req (capture_req),
        .capture_cmd (capture_cmd),
        .capture_ack (capture_ack),
        .ram_wr      (ram_wr),
        .status      (status)
    );

    frame_ram ram_i (
        .clk      (clk),
        .wr       (ram_wr),
        .rd_block (rd_block),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // ======================================================================
    // Readout path
    // ======================================================================
    fletcher_checksum checksum_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (cs_clear),
        .accept (cs_accept),
        .word   (cs_word),
        .sum    (cs_sum)
    );

    readout_sequencer readout_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .readout_req   (readout_req),
        .readout_cmd   (readout_cmd),
        .readout_ack   (readout_ack),
        .rd_block      (rd_block),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .cs_clear      (cs_clear),
        .cs_accept     (cs_accept),
        .cs_word       (cs_word),
        .cs_sum        (cs_sum),
        .readout_valid (readout_valid),
        .readout_data  (readout_data),
        .readout_ready (readout_ready)
    );

endmodule

//--- tests/img_controller_assert.sv
module img_controller_assert (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          capture_req,
    input logic                          capture_ack,
    input logic                          readout_req,
    input logic                          readout_ack,
    input logic                          readout_valid,
    input logic [img_pkg::word_bits-1:0] readout_data,
    input logic                          readout_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // ======================================================================
    // Four-phase handshakes
    // ======================================================================
    capture_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(capture_req) |-> !capture_ack)
        else $error("capture_req rose while capture_ack was high");

    readout_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(readout_req) |-> !readout_ack)
        else $error("readout_req rose while readout_ack was high");

    // Ack may only drop once the request has dropped
    capture_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(capture_ack) |-> !$past(capture_req))
        else $error("capture_ack fell while capture_req was high");

    readout_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(readout_ack) |-> !$past(readout_req))
        else $error("readout_ack fell while readout_req was high");

    // Output stream
    stream_hold: assert property (@(posedge clk) disable iff (!rst_n)
        readout_valid && !readout_ready |=> readout_valid && $stable(readout_data))
        else $error("readout word changed or dropped under back-pressure");

    stream_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !readout_req && !readout_ack |-> !readout_valid)
        else $error("readout_valid high outside a readout");

endmodule

//--- tests/img_controller_tb.sv
module img_controller_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycle_limit = 40000;

    logic                          clk = 1'b0;
    logic                          rst_n;
    img_pkg::pixel_in_t            pixel_in;
    logic                          capture_req;
    img_pkg::capture_cmd_t         capture_cmd;
    logic                          capture_ack;
    img_pkg::capture_status_t      status;
    logic                          readout_req;
    img_pkg::readout_cmd_t         readout_cmd;
    logic                          readout_ack;
    logic                          readout_valid;
    logic [img_pkg::word_bits-1:0] readout_data;
    logic                          readout_ready;

    integer seed;
    int     cycle_count = 0;
    int     exp_high;
    int     exp_shadow;

    // Reference copy of both frame memory blocks
    logic [15:0] mem_model [img_pkg::block_count][img_pkg::pixel_count];

    img_controller dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pixel_in      (pixel_in),
        .capture_req   (capture_req),
        .capture_cmd   (capture_cmd),
        .capture_ack   (capture_ack),
        .status        (status),
        .readout_req   (readout_req),
        .readout_cmd   (readout_cmd),
        .readout_ack   (readout_ack),
        .readout_valid (readout_valid),
        .readout_data  (readout_data),
        .readout_ready (readout_ready)
    );

    bind img_controller img_controller_assert assert_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture_req   (capture_req),
        .capture_ack   (capture_ack),
        .readout_req   (readout_req),
        .readout_ack   (readout_ack),
        .readout_valid (readout_valid),
        .readout_data  (readout_data),
        .readout_ready (readout_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // ======================================================================
    // Pixel stream with line and frame blanking
    // ======================================================================
    task automatic drive_frame(input bit store, input logic blk);
        logic [31:0] rnd;
        logic [11:0] px;
        int          x;
        int          y;
        pixel_in = '0;
        repeat (4) @(negedge clk);
        pixel_in.fv = 1'b1;
        repeat (2) @(negedge clk);
        for (y = 0; y < img_pkg::img_height; y++) begin
            for (x = 0; x < img_pkg::img_width; x++) begin
                rnd = $random(seed);
                // Bias toward highlight and shadow values
                case (rnd[1:0])
                    2'd0:    px = {7'h7f, rnd[8:4]};
                    2'd1:    px = {7'h00, rnd[8:4]};
                    default: px = rnd[27:16];
                endcase
                pixel_in.lv    = 1'b1;
                pixel_in.pixel = px;
                if (store) begin
                    mem_model[blk][y*img_pkg::img_width + x] = {px[7:0], 4'h0, px[11:8]};
                    if (x % img_pkg::stat_tile == 0 && y % img_pkg::stat_tile == 0) begin
                        if (px[11:5] == 7'h7f)
                            exp_high++;
                        else if (px[11:5] == 7'h00)
                            exp_shadow++;
                    end
                end
                @(negedge clk);
            end
            pixel_in.lv    = 1'b0;
            pixel_in.pixel = '0;
            repeat (3) @(negedge clk);
        end
        pixel_in.fv = 1'b0;
    endtask

    task automatic capture_block(input logic blk, input logic skip);
        exp_high    = 0;
        exp_shadow  = 0;
        capture_cmd = '{block: blk, skip: skip};
        capture_req = 1'b1;
        if (skip)
            drive_frame(1'b0, blk);
        drive_frame(1'b1, blk);
        while (!capture_ack)
            @(negedge clk);
        check_value(status.pixels, img_pkg::pixel_count, "status pixel count");
        check_value(status.highlights, exp_high, "status highlight count");
        check_value(status.shadows, exp_shadow, "status shadow count");
        capture_req = 1'b0;
        while (capture_ack)
            @(negedge clk);
    endtask

    // ======================================================================
    // Readout with random back-pressure
    // ======================================================================
    task automatic stream_block(input logic blk, input logic thumb);
        logic [15:0] expected [$];
        logic [15:0] received [$];
        logic [63:0] header;
        logic [31:0] rnd;
        logic [31:0] result;
        logic [31:0] reversed;
        logic [15:0] w;
        int          a;
        int          b;
        int          idx;
        header[63:32] = $random(seed);
        header[31:0]  = $random(seed);
        for (idx = 0; idx < img_pkg::header_words; idx++)
            expected.push_back(header[63 - 16*idx -: 16]);
        for (idx = 0; idx < img_pkg::pixel_count; idx++) begin
            if (!thumb ||
                ((idx % img_pkg::img_width) % img_pkg::thumb_tile < img_pkg::thumb_keep &&
                 (idx / img_pkg::img_width) % img_pkg::thumb_tile < img_pkg::thumb_keep))
                expected.push_back(mem_model[blk][idx]);
        end
        // Fletcher-32 over byte-swapped words
        a = 0;
        b = 0;
        foreach (expected[i]) begin
            w = {expected[i][7:0], expected[i][15:8]};
            a = (a + w) % 65535;
            b = (b + a) % 65535;
        end
        result   = {b[15:0], a[15:0]};
        reversed = {result[7:0], result[15:8], result[23:16], result[31:24]};
        expected.push_back(reversed[31:16]);
        expected.push_back(reversed[15:0]);
        expected.push_back(16'h0000);
        expected.push_back(16'h0000);

        readout_cmd = '{block: blk, thumb: thumb, header: header};
        readout_req = 1'b1;
        @(negedge clk);
        while (!readout_ack) begin
            rnd = $random(seed);
            readout_ready = (rnd[7:0] % 10) < 6;
            if (readout_valid && readout_ready)
                received.push_back(readout_data);
            @(negedge clk);
        end
        check_value(received.size(), expected.size(), "words before readout ack");
        foreach (expected[i])
            check_value(received[i], expected[i], $sformatf("readout word %0d", i));
        readout_ready = 1'b0;
        readout_req   = 1'b0;
        while (readout_ack)
            @(negedge clk);
    endtask

    initial begin
        seed          = 30;
        rst_n         = 1'b0;
        pixel_in      = '0;
        capture_req   = 1'b0;
        capture_cmd   = '0;
        readout_req   = 1'b0;
        readout_cmd   = '0;
        readout_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value(capture_ack, 1'b0, "capture ack after reset");
        check_value(readout_ack, 1'b0, "readout ack after reset");
        check_value(readout_valid, 1'b0, "readout valid after reset");
        check_value(status, '0, "status after reset");

        capture_block(1'b0, 1'b0);
        capture_block(1'b1, 1'b1);
        stream_block(1'b1, 1'b0);
        stream_block(1'b0, 1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- filelist.f
verilog/img_pkg.sv
verilog/frame_capture.sv
verilog/frame_ram.sv
verilog/fletcher_checksum.sv
verilog/readout_sequencer.sv
verilog/img_controller.sv
tests/img_controller_assert.sv
tests/img_controller_tb.sv
